// ==== project.f ====
common/csr_map_pkg.sv
common/csr_cfg_pkg.sv
common/csr_wr_if.sv
common/csr_view_if.sv
logic/csr_op_unit.sv
trap/csr_trap_regs.sv
counters/csr_counters.sv
logic/csr_read_mux.sv
logic/csr_regfile.sv
testbench/tb_clock.sv
testbench/csr_regfile_asserts.sv
testbench/tb_csr_regfile.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the CSR register file testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_csr_regfile \
  -f project.f \
  -o sim_csr_regfile

status=0
out=$(./obj_dir/sim_csr_regfile) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && echo "$out" | grep -qx "Done: no errors"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== testbench/tb_csr_regfile.sv ====
module tb_csr_regfile;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_CYCLES = 3000;
  localparam logic [11:0] KNOWN_ADDR [11] = '{
    csr_map_pkg::CSR_MSTATUS, csr_map_pkg::CSR_MISA, csr_map_pkg::CSR_MTVEC,
    csr_map_pkg::CSR_MCOUNTINHIBIT, csr_map_pkg::CSR_MEPC, csr_map_pkg::CSR_MCAUSE,
    csr_map_pkg::CSR_MCYCLE, csr_map_pkg::CSR_MINSTRET, csr_map_pkg::CSR_MCYCLEH,
    csr_map_pkg::CSR_MINSTRETH, csr_map_pkg::CSR_MHARTID
  };

  logic clk, rst_n;
  logic [3:0] core_id;
  logic [5:0] cluster_id;
  logic [31:0] boot_addr, csr_wdata, csr_rdata, pc_if, pc_id, mepc;
  logic csr_access, illegal_csr, save_if, save_id, save_cause, restore_mret;
  logic insn_ret, irq_enable;
  csr_map_pkg::csr_addr_e   csr_addr;
  csr_map_pkg::csr_op_e     csr_op;
  csr_map_pkg::exc_cause_t  cause;
  integer seed;

  // reference copy of the architectural state
  logic        m_mie, m_mpie, m_inh_cy, m_inh_ir;
  logic [31:0] m_mepc;
  logic [5:0]  m_mcause;
  logic [63:0] m_mcycle, m_minstret;

  tb_clock u_clock (.clk_o(clk), .rst_no(rst_n));

  csr_regfile csr_regfile_i (
    .clk_i(clk), .rst_ni(rst_n), .core_id_i(core_id), .cluster_id_i(cluster_id),
    .boot_addr_i(boot_addr), .csr_access_i(csr_access), .csr_addr_i(csr_addr),
    .csr_op_i(csr_op), .csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata),
    .illegal_csr_o(illegal_csr), .pc_if_i(pc_if), .pc_id_i(pc_id), .save_if_i(save_if),
    .save_id_i(save_id), .save_cause_i(save_cause), .cause_i(cause),
    .restore_mret_i(restore_mret), .insn_ret_i(insn_ret), .irq_enable_o(irq_enable),
    .mepc_o(mepc)
  );

  bind csr_regfile csr_regfile_asserts u_asserts (
    .clk_i(clk_i), .rst_ni(rst_ni), .csr_access_i(csr_access_i), .csr_addr_i(csr_addr_i),
    .csr_rdata_i(csr_rdata_o), .illegal_csr_i(illegal_csr_o), .irq_enable_i(irq_enable_o)
  );

  //////////////////////////////////////////////////
  // reference model

  function automatic logic addr_known(input logic [11:0] a);
    foreach (KNOWN_ADDR[i]) if (KNOWN_ADDR[i] == a) return 1'b1;
    return 1'b0;
  endfunction

  function automatic logic [31:0] expected_read(input logic [11:0] a);
    logic [31:0] r;
    r = '0;
    case (a)
      12'h300: r = {19'b0, 2'b11, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};  // mpp stuck at M
      12'h301: r = 32'h4000_0104;  // mxl 1, I and C
      12'h305: r = boot_addr;
      12'h320: r = 32'hFFFF_FFF8 | {29'b0, m_inh_ir, 1'b0, m_inh_cy};
      12'h341: r = m_mepc;
      12'h342: r = {m_mcause[5], 26'b0, m_mcause[4:0]};
      12'hB00: r = m_mcycle[31:0];
      12'hB80: r = m_mcycle[63:32];
      12'hB02: r = m_minstret[31:0];
      12'hB82: r = m_minstret[63:32];
      12'hF14: r = {21'b0, cluster_id, 1'b0, core_id};
      default: r = '0;
    endcase
    return r;
  endfunction

  // state after the coming edge
  task automatic advance_model();
    logic [11:0] a;
    logic [31:0] w, rd;
    logic        we, old_mie, old_mpie;
    a        = csr_addr;
    rd       = expected_read(a);
    we       = csr_access && csr_op != csr_map_pkg::CSR_OP_READ && a[11:10] != 2'b11;
    old_mie  = m_mie;
    old_mpie = m_mpie;
    case (csr_op)
      csr_map_pkg::CSR_OP_SET:   w = csr_wdata | rd;
      csr_map_pkg::CSR_OP_CLEAR: w = ~csr_wdata & rd;
      default:                   w = csr_wdata;
    endcase
    if (!m_inh_cy) m_mcycle++;  // old inhibit bits gate this edge
    if (insn_ret && !m_inh_ir) m_minstret++;
    if (we) begin
      case (a)
        12'h300: begin
          m_mie  = w[3];
          m_mpie = w[7];
        end
        12'h341: m_mepc = w;
        12'h342: m_mcause = {w[31], w[4:0]};
        12'h320: begin
          m_inh_cy = w[0];
          m_inh_ir = w[2];
        end
        12'hB00: m_mcycle[31:0] = w;
        12'hB80: m_mcycle[63:32] = w;
        12'hB02: m_minstret[31:0] = w;
        12'hB82: m_minstret[63:32] = w;
        default: ;
      endcase
    end
    if (save_cause) begin  // trap entry beats the csr port
      m_mpie   = old_mie;
      m_mie    = 1'b0;
      m_mepc   = save_if ? pc_if : pc_id;
      m_mcause = cause;
    end else if (restore_mret) begin
      m_mie  = old_mpie;
      m_mpie = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus and checks

  task automatic pick_stimulus();
    logic [31:0] r, r2;
    r  = $random(seed);
    r2 = $random(seed);
    csr_access = (r[1:0] != 2'b00);
    csr_op     = csr_map_pkg::csr_op_e'(r[3:2]);
    if (r[7:4] < 4'd13) csr_addr = csr_map_pkg::csr_addr_e'(KNOWN_ADDR[int'(r[11:8]) % 11]);
    else csr_addr = csr_map_pkg::csr_addr_e'(r[23:12]);  // mostly unknown
    save_cause   = (r[26:24] == 3'b000);
    restore_mret = (r[29:27] == 3'b000);
    insn_ret     = r[30];
    save_if      = r[31];
    save_id      = ~r[31];
    cause        = r2[5:0];
    core_id      = r2[9:6];
    cluster_id   = r2[15:10];
    csr_wdata    = $random(seed);
    pc_if        = $random(seed);
    pc_id        = $random(seed);
    boot_addr    = $random(seed);
  endtask

  task automatic fail_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_protocol();
    $display("a bound protocol assertion failed by %0t ns", $time);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_outputs();
    logic [11:0] a;
    logic [31:0] exp_rd;
    logic        exp_ill;
    a       = csr_addr;
    exp_rd  = expected_read(a);
    exp_ill = csr_access && (!addr_known(a) ||
              (csr_op != csr_map_pkg::CSR_OP_READ && a[11:10] == 2'b11));
    if (csr_access) begin
      assert (csr_rdata == exp_rd) else fail_mismatch("csr_rdata_o", csr_rdata, exp_rd);
    end
    assert (illegal_csr == exp_ill)
      else fail_mismatch("illegal_csr_o", 32'(illegal_csr), 32'(exp_ill));
    assert (irq_enable == m_mie) else fail_mismatch("irq_enable_o", 32'(irq_enable), 32'(m_mie));
    assert (mepc == m_mepc) else fail_mismatch("mepc_o", mepc, m_mepc);
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    seed = 32'h1a5e2d7a;
    {csr_access, save_if, save_id, save_cause, restore_mret, insn_ret} = '0;
    {core_id, cluster_id, boot_addr, csr_wdata, pc_if, pc_id} = '0;
    csr_addr = csr_map_pkg::CSR_MSTATUS;
    csr_op   = csr_map_pkg::CSR_OP_READ;
    cause    = '0;
    {m_mie, m_mpie, m_inh_cy, m_inh_ir, m_mepc, m_mcause, m_mcycle, m_minstret} = '0;
    @(posedge rst_n);  // 10 ns past an edge already
    for (int n = 0; n < NUM_CYCLES; n++) begin
      pick_stimulus();
      #70;  // outputs settled, well before the edge
      compare_outputs();
      advance_model();
      @(posedge clk);
      #10;
      // concurrent checks of this edge have run by now
      assert (csr_regfile_i.u_asserts.fail_cnt == 0) else fail_protocol();
    end
    $display("Done: no errors");
    $finish;
  end

  // watchdog covers reset, every test cycle and a margin
  initial begin
    #((NUM_CYCLES + 20) * 100);
    $display("timeout: run did not finish within its cycle budget");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== testbench/csr_regfile_asserts.sv ====
module csr_regfile_asserts (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         csr_access_i,
  input csr_map_pkg::csr_addr_e       csr_addr_i,
  input logic [csr_map_pkg::XLEN-1:0] csr_rdata_i,
  input logic                         illegal_csr_i,
  input logic                         irq_enable_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // failed checks so far

  //////////////////////////////////////////////////
  // port protocol

  // no access, no illegal flag
  illegal_needs_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !csr_access_i |-> !illegal_csr_i
  ) else begin
    $error("illegal_csr_o high without an access");
    fail_cnt++;
  end

  // interrupts stay off right after reset
  irq_off_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !irq_enable_i
  ) else begin
    $error("irq_enable_o high in the first cycle after reset");
    fail_cnt++;
  end

  // no time counter, so bit 1 never reads as set
  inhibit_bit1_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (csr_access_i && csr_addr_i == csr_map_pkg::CSR_MCOUNTINHIBIT) |-> !csr_rdata_i[1]
  ) else begin
    $error("mcountinhibit bit 1 read as one");
    fail_cnt++;
  end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned PERIOD     = 100;
  localparam int unsigned RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release 10 ns after an edge, clear of the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10 rst_no = 1'b1;
  end

endmodule

// ==== logic/csr_regfile.sv ====
module csr_regfile (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // hart identity
  input  logic [3:0]                   core_id_i,
  input  logic [5:0]                   cluster_id_i,
  input  logic [csr_map_pkg::XLEN-1:0] boot_addr_i,

  // sram-like csr port, single cycle
  input  logic                         csr_access_i,
  input  csr_map_pkg::csr_addr_e       csr_addr_i,
  input  csr_map_pkg::csr_op_e         csr_op_i,
  input  logic [csr_map_pkg::XLEN-1:0] csr_wdata_i,
  output logic [csr_map_pkg::XLEN-1:0] csr_rdata_o,
  output logic                         illegal_csr_o,

  // trap control
  input  logic [csr_map_pkg::XLEN-1:0] pc_if_i,
  input  logic [csr_map_pkg::XLEN-1:0] pc_id_i,
  input  logic                         save_if_i,
  input  logic                         save_id_i,     // ID is the default pc source
  input  logic                         save_cause_i,
  input  csr_map_pkg::exc_cause_t      cause_i,
  input  logic                         restore_mret_i,

  input  logic                         insn_ret_i,

  output logic                         irq_enable_o,
  output logic [csr_map_pkg::XLEN-1:0] mepc_o
);

  csr_wr_if   wr_bus ();
  csr_view_if view_bus ();

  logic [csr_map_pkg::XLEN-1:0] rdata;  // also the set/clear operand

  csr_op_unit u_op (
    .access_i (csr_access_i),
    .addr_i   (csr_addr_i),
    .op_i     (csr_op_i),
    .wdata_i  (csr_wdata_i),
    .rdata_i  (rdata),
    .wr       (wr_bus)
  );

  csr_trap_regs u_trap (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr             (wr_bus),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .save_if_i      (save_if_i),
    .save_cause_i   (save_cause_i),
    .cause_i        (cause_i),
    .restore_mret_i (restore_mret_i),
    .view           (view_bus),
    .irq_enable_o   (irq_enable_o),
    .mepc_o         (mepc_o)
  );

  csr_counters u_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr         (wr_bus),
    .insn_ret_i (insn_ret_i),
    .view       (view_bus)
  );

  csr_read_mux u_rd (
    .access_i     (csr_access_i),
    .addr_i       (csr_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .wr           (wr_bus),
    .view         (view_bus),
    .rdata_o      (rdata),
    .illegal_o    (illegal_csr_o)
  );

  assign csr_rdata_o = rdata;

endmodule

// ==== logic/csr_read_mux.sv ====
module csr_read_mux (
  input  logic                         access_i,
  input  csr_map_pkg::csr_addr_e       addr_i,
  input  logic [3:0]                   core_id_i,
  input  logic [5:0]                   cluster_id_i,
  input  logic [csr_map_pkg::XLEN-1:0] boot_addr_i,

  csr_wr_if.sink                       wr,    // for the ro_write flag
  csr_view_if.rd                       view,

  output logic [csr_map_pkg::XLEN-1:0] rdata_o,
  output logic                         illegal_o
);

  localparam int unsigned XLEN  = csr_map_pkg::XLEN;
  localparam int unsigned CNT_W = csr_cfg_pkg::CNT_W;
  localparam int unsigned HID_PAD = XLEN - csr_cfg_pkg::HART_ID_W - 1;

  logic [XLEN-1:0] rdata;
  logic            unknown;  // address not implemented

  //////////////////////////////////////////////////
  // read select

  always_comb begin
    rdata   = '0;
    unknown = 1'b0;
    case (addr_i)
      csr_map_pkg::CSR_MSTATUS: begin
        // only mie, mpie and mpp are live
        rdata[csr_map_pkg::MSTATUS_MIE_BIT]      = view.mstatus.mie;
        rdata[csr_map_pkg::MSTATUS_MPIE_BIT]     = view.mstatus.mpie;
        rdata[csr_map_pkg::MSTATUS_MPP_LSB +: 2] = view.mstatus.mpp;
      end

      csr_map_pkg::CSR_MISA:   rdata = csr_cfg_pkg::MISA_VALUE;
      csr_map_pkg::CSR_MTVEC:  rdata = boot_addr_i;  // trap vector is the boot address
      csr_map_pkg::CSR_MEPC:   rdata = view.mepc;
      csr_map_pkg::CSR_MCAUSE: rdata = {view.mcause[5], 26'b0, view.mcause[4:0]};

      // cluster at 10:5, core at 3:0, bit 4 zero
      csr_map_pkg::CSR_MHARTID: rdata = {{HID_PAD{1'b0}}, cluster_id_i, 1'b0, core_id_i};

      csr_map_pkg::CSR_MCOUNTINHIBIT: begin
        rdata = csr_cfg_pkg::MCOUNTINHIBIT_FORCE | {29'b0, view.mcountinhibit};
      end

      // counter halves
      csr_map_pkg::CSR_MCYCLE:    rdata = view.mcycle[XLEN-1:0];
      csr_map_pkg::CSR_MCYCLEH:   rdata = view.mcycle[CNT_W-1:XLEN];
      csr_map_pkg::CSR_MINSTRET:  rdata = view.minstret[XLEN-1:0];
      csr_map_pkg::CSR_MINSTRETH: rdata = view.minstret[CNT_W-1:XLEN];

      default: unknown = 1'b1;
    endcase
  end

  assign rdata_o = rdata;

  // no access, no illegal flag
  assign illegal_o = access_i & (unknown | wr.ro_write);

endmodule

// ==== counters/csr_counters.sv ====
module csr_counters (
  input  logic   clk_i,
  input  logic   rst_ni,

  csr_wr_if.sink wr,

  input  logic   insn_ret_i,  // one instruction retired

  csr_view_if.cnt view
);

  localparam int unsigned XLEN  = csr_map_pkg::XLEN;
  localparam int unsigned CNT_W = csr_cfg_pkg::CNT_W;

  // index 0 mcycle, index 1 minstret
  logic [CNT_W-1:0] cnt_q [2];
  logic [CNT_W-1:0] cnt_d [2];
  logic [1:0]       incr;
  logic [1:0]       lo_we;
  logic [1:0]       hi_we;
  logic             inh_cy_q, inh_ir_q;  // mcountinhibit bits 0 and 2
  logic             inh_we;

  //////////////////////////////////////////////////
  // write decode

  assign lo_we[0] = wr.we & (wr.addr == csr_map_pkg::CSR_MCYCLE);
  assign hi_we[0] = wr.we & (wr.addr == csr_map_pkg::CSR_MCYCLEH);
  assign lo_we[1] = wr.we & (wr.addr == csr_map_pkg::CSR_MINSTRET);
  assign hi_we[1] = wr.we & (wr.addr == csr_map_pkg::CSR_MINSTRETH);
  assign inh_we   = wr.we & (wr.addr == csr_map_pkg::CSR_MCOUNTINHIBIT);

  // events, gated by the current inhibit bits
  assign incr[0] = ~inh_cy_q;               // every cycle
  assign incr[1] = insn_ret_i & ~inh_ir_q;

  // increment, then let a half write replace its half
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      cnt_d[i] = cnt_q[i] + CNT_W'(incr[i]);
      if (lo_we[i]) cnt_d[i][XLEN-1:0] = wr.wdata;
      if (hi_we[i]) cnt_d[i][CNT_W-1:XLEN] = wr.wdata;
    end
  end

  //////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q[0] <= '0;
      cnt_q[1] <= '0;
      inh_cy_q <= 1'b0;
      inh_ir_q <= 1'b0;
    end else begin
      cnt_q[0] <= cnt_d[0];
      cnt_q[1] <= cnt_d[1];
      if (inh_we) begin
        inh_cy_q <= wr.wdata[0];
        inh_ir_q <= wr.wdata[2];
      end
    end
  end

  assign view.mcycle        = cnt_q[0];
  assign view.minstret      = cnt_q[1];
  assign view.mcountinhibit = {inh_ir_q, 1'b0, inh_cy_q};  // no time counter, bit 1 zero

endmodule

// ==== trap/csr_trap_regs.sv ====
module csr_trap_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  csr_wr_if.sink                       wr,

  input  logic [csr_map_pkg::XLEN-1:0] pc_if_i,
  input  logic [csr_map_pkg::XLEN-1:0] pc_id_i,
  input  logic                         save_if_i,      // take pc from IF, else ID
  input  logic                         save_cause_i,   // trap entry
  input  csr_map_pkg::exc_cause_t      cause_i,
  input  logic                         restore_mret_i,

  csr_view_if.trap                     view,

  output logic                         irq_enable_o,
  output logic [csr_map_pkg::XLEN-1:0] mepc_o
);

  csr_map_pkg::mstatus_t        mstatus_q, mstatus_d;
  logic [csr_map_pkg::XLEN-1:0] mepc_q, mepc_d;
  csr_map_pkg::exc_cause_t      mcause_q, mcause_d;

  //////////////////////////////////////////////////
  // next state

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // csr writes first
    if (wr.we) begin
      case (wr.addr)
        csr_map_pkg::CSR_MSTATUS: begin
          mstatus_d.mie  = wr.wdata[csr_map_pkg::MSTATUS_MIE_BIT];
          mstatus_d.mpie = wr.wdata[csr_map_pkg::MSTATUS_MPIE_BIT];
        end
        csr_map_pkg::CSR_MEPC:   mepc_d   = wr.wdata;
        csr_map_pkg::CSR_MCAUSE: mcause_d = {wr.wdata[31], wr.wdata[4:0]};  // flag + code
        default: ;  // not ours
      endcase
    end

    // trap controller wins over the csr port
    if (save_cause_i) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = save_if_i ? pc_if_i : pc_id_i;
      mcause_d       = cause_i;
    end else if (restore_mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end

    mstatus_d.mpp = csr_map_pkg::PRIV_LVL_M;  // hardwired
  end

  //////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q <= '{mie: 1'b0, mpie: 1'b0, mpp: csr_map_pkg::PRIV_LVL_M};
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign view.mstatus = mstatus_q;
  assign view.mepc    = mepc_q;
  assign view.mcause  = mcause_q;

  assign irq_enable_o = mstatus_q.mie;  // global machine irq enable
  assign mepc_o       = mepc_q;

endmodule

// ==== logic/csr_op_unit.sv ====
module csr_op_unit (
  input  logic                         access_i,
  input  csr_map_pkg::csr_addr_e       addr_i,
  input  csr_map_pkg::csr_op_e         op_i,
  input  logic [csr_map_pkg::XLEN-1:0] wdata_i,
  input  logic [csr_map_pkg::XLEN-1:0] rdata_i,  // merge operand, from read mux
  csr_wr_if.op                         wr
);

  logic [csr_map_pkg::CSR_ADDR_W-1:0] addr_raw;
  logic [csr_map_pkg::XLEN-1:0]       wdata_eff;
  logic                               is_write;   // any op but read
  logic                               ro_hit;

  assign addr_raw = addr_i;
  assign ro_hit   = (addr_raw[csr_map_pkg::CSR_ADDR_W-1 -: 2] == csr_map_pkg::CSR_RO_PREFIX);

  // op decode and read-modify-write merge
  always_comb begin
    wdata_eff = wdata_i;
    is_write  = 1'b1;
    unique case (op_i)
      csr_map_pkg::CSR_OP_WRITE: wdata_eff = wdata_i;
      csr_map_pkg::CSR_OP_SET:   wdata_eff = wdata_i | rdata_i;   // set bits
      csr_map_pkg::CSR_OP_CLEAR: wdata_eff = ~wdata_i & rdata_i;  // clear bits
      default: begin
        // plain read, nothing to commit
        wdata_eff = wdata_i;
        is_write  = 1'b0;
      end
    endcase
  end

  assign wr.addr     = addr_i;
  assign wr.wdata    = wdata_eff;
  assign wr.ro_write = access_i & is_write & ro_hit;
  assign wr.we       = access_i & is_write & ~ro_hit;  // ro space never written

endmodule

// ==== common/csr_view_if.sv ====
// current register state, toward the read side
interface csr_view_if;

  csr_map_pkg::mstatus_t         mstatus;
  logic [csr_map_pkg::XLEN-1:0]  mepc;
  csr_map_pkg::exc_cause_t       mcause;
  logic [csr_cfg_pkg::CNT_W-1:0] mcycle;
  logic [csr_cfg_pkg::CNT_W-1:0] minstret;
  logic [2:0]                    mcountinhibit;  // bit 1 held at zero

  // trap state owner
  modport trap (
    output mstatus,
    output mepc,
    output mcause
  );

  // counter owner
  modport cnt (
    output mcycle,
    output minstret,
    output mcountinhibit
  );

  modport rd (
    input mstatus,
    input mepc,
    input mcause,
    input mcycle,
    input minstret,
    input mcountinhibit
  );

endinterface

// ==== common/csr_wr_if.sv ====
// resolved csr write, one cycle wide
interface csr_wr_if;

  logic                         we;        // commit at next edge
  csr_map_pkg::csr_addr_e       addr;
  logic [csr_map_pkg::XLEN-1:0] wdata;     // already merged for set/clear
  logic                         ro_write;  // write attempt into read-only space

  modport op (
    output we,
    output addr,
    output wdata,
    output ro_write
  );

  modport sink (
    input we,
    input addr,
    input wdata,
    input ro_write
  );

endinterface

// ==== common/csr_cfg_pkg.sv ====
package csr_cfg_pkg;

  // rv32 with compressed ext, no M
  localparam logic [1:0] MXL = 2'd1;  // 32-bit xlen in machine mode

  localparam logic [31:0] MISA_VALUE =
      (32'd1      <<  2)   // C
    | (32'd1      <<  8)   // I
    | (32'(MXL)   << 30);  // mxl field

  // mcycle and minstret width
  localparam int unsigned CNT_W = 64;

  // core id 4 bits plus cluster id 6 bits
  localparam int unsigned HART_ID_W = 10;

  // no hpm counters here, so bits 31:3 stick at one
  localparam logic [31:0] MCOUNTINHIBIT_FORCE = 32'hFFFF_FFF8;

endpackage

// ==== common/csr_map_pkg.sv ====
package csr_map_pkg;

  //////////////////////////////////////////////////
  // data path

  localparam int unsigned XLEN = 32;  // machine word

  //////////////////////////////////////////////////
  // csr address map, machine mode only

  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,  // WARL, writes dropped
    CSR_MTVEC         = 12'h305,  // boot address, writes dropped
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHARTID       = 12'hF14   // read-only space
  } csr_addr_e;

  localparam int unsigned CSR_ADDR_W = $bits(csr_addr_e);

  // top two address bits 11 mark read-only space
  localparam logic [1:0] CSR_RO_PREFIX = 2'b11;

  //////////////////////////////////////////////////
  // access ops and privilege

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11   // the only level in use
  } priv_lvl_e;

  // bit 5 interrupt flag, bits 4:0 code
  typedef logic [5:0] exc_cause_t;

  // stored part of mstatus
  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;  // mpp at 12:11

endpackage
